// ==== Bender.yml ====
package:
  name: immu

sources:
  # Packages first
  - src/immu_cfg_pkg.sv
  - src/immu_msr_pkg.sv
  # RTL, leaves before the top
  - src/tlb_entry_ram.sv
  - src/msr_decode.sv
  - src/immu.sv
  - src/fetch_result_queue.sv
  - src/immu_top.sv
  # Testbench
  - target: test
    files:
      - verification/immu_tb.sv

// ==== files.f ====
src/immu_cfg_pkg.sv
src/immu_msr_pkg.sv
src/tlb_entry_ram.sv
src/msr_decode.sv
src/immu.sv
src/fetch_result_queue.sv
src/immu_top.sv
verification/immu_tb.sv

// ==== src/fetch_result_queue.sv ====
// Fetch translation result queue
// In-order circular buffer of lookup results, head slot shown on the
// res_* outputs, one credit pulse returned per accepted pop
`timescale 1ns/1ps
`default_nettype none

module fetch_result_queue (
   input  wire                 clk,
   input  wire                 reset,
   input  wire                 push,
   input  immu_cfg_pkg::vpn_t  push_ppn,
   input  wire                 push_itm,
   input  wire                 push_ipf,
   input  wire                 push_uncached,
   input  wire                 pop,
   output logic                res_valid,
   output immu_cfg_pkg::vpn_t  res_ppn,
   output logic                res_itm,
   output logic                res_ipf,
   output logic                res_uncached,
   output logic                credit
);
   import immu_cfg_pkg::*;

   // Payload slots
   vpn_t ppn_mem [QUEUE_DEPTH];
   logic itm_mem [QUEUE_DEPTH];
   logic ipf_mem [QUEUE_DEPTH];
   logic unc_mem [QUEUE_DEPTH];

   queue_ptr_t wr_ptr;
   queue_ptr_t rd_ptr;
   queue_cnt_t count;
   logic pop_ok;

   // Wrap at the last slot, depth need not be a power of two
   function automatic queue_ptr_t ptr_next(input queue_ptr_t ptr);
      queue_ptr_t nxt;
      nxt = (ptr == queue_ptr_t'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
      return nxt;
   endfunction

   assign res_valid = (count != '0);
   assign pop_ok = pop & res_valid;

   // Head slot
   assign res_ppn = ppn_mem[rd_ptr];
   assign res_itm = itm_mem[rd_ptr];
   assign res_ipf = ipf_mem[rd_ptr];
   assign res_uncached = unc_mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         ppn_mem[wr_ptr] <= push_ppn;
         itm_mem[wr_ptr] <= push_itm;
         ipf_mem[wr_ptr] <= push_ipf;
         unc_mem[wr_ptr] <= push_uncached;
      end
   end

   // Pointers, count and credit return
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         credit <= 1'b0;
      end
      else
      begin
         // Requester credits keep push off a full queue
         if (push)
            wr_ptr <= ptr_next(wr_ptr);
         if (pop_ok)
            rd_ptr <= ptr_next(rd_ptr);
         if (push && !pop_ok)
            count <= count + 1'b1;
         else if (!push && pop_ok)
            count <= count - 1'b1;
         credit <= pop_ok;
      end
   end

endmodule

`default_nettype wire

// ==== src/immu.sv ====
// Instruction TLB lookup
// Registers the request, reads the direct-mapped TLB words, compares
// the tag, checks execute permission for the current mode and forms
// the physical page with its miss, page fault and uncached flags
`timescale 1ns/1ps
`default_nettype none

module immu #(
   parameter int unsigned ENABLE_UNCACHED_SEG = 1
) (
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      re,
   input  immu_cfg_pkg::vpn_t       vpn,
   input  wire                      psr_imme,
   input  wire                      psr_rm,
   input  wire                      tlbl_we,
   input  wire                      tlbh_we,
   input  immu_cfg_pkg::tlb_idx_t   tlb_widx,
   input  immu_cfg_pkg::msr_data_t  tlb_wdata,
   output logic                     valid,
   output immu_cfg_pkg::vpn_t       ppn,
   output logic                     itm,
   output logic                     ipf,
   output logic                     uncached
);
   import immu_cfg_pkg::*;
   import immu_msr_pkg::*;

   // Lookup stage registers
   vpn_t vpn_q;
   logic imme_q;
   logic rm_q;

   // Entry words read at the accept edge
   msr_data_t tlbl_q;
   msr_data_t tlbh_q;

   // Entry fields
   logic tlb_v;
   vpn_t tlb_tag;
   logic tlb_ux;
   logic tlb_rx;
   logic tlb_unc;
   vpn_t tlb_ppn;

   logic tlb_miss;
   logic perm_denied;
   logic seg_unc;

   // Set index from the low VPN bits
   tlb_entry_ram u_tlbl (
      .clk   (clk),
      .re    (re),
      .raddr (vpn[TLB_IDX_W-1:0]),
      .rdata (tlbl_q),
      .we    (tlbl_we),
      .waddr (tlb_widx),
      .wdata (tlb_wdata)
   );

   tlb_entry_ram u_tlbh (
      .clk   (clk),
      .re    (re),
      .raddr (vpn[TLB_IDX_W-1:0]),
      .rdata (tlbh_q),
      .we    (tlbh_we),
      .waddr (tlb_widx),
      .wdata (tlb_wdata)
   );

   // Mode bits sampled with the request
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         valid <= 1'b0;
         imme_q <= 1'b0;
         rm_q <= 1'b0;
      end
      else
      begin
         valid <= re;
         if (re)
         begin
            imme_q <= psr_imme;
            rm_q <= psr_rm;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (re)
      begin
         vpn_q <= vpn;
      end
   end

   // P and S are stored but not decoded
   assign tlb_v = tlbl_q[TLBL_V_BIT];
   assign tlb_tag = tlbl_q[TLBL_TAG_LSB +: VPN_W];
   assign tlb_ux = tlbh_q[TLBH_UX_BIT];
   assign tlb_rx = tlbh_q[TLBH_RX_BIT];
   assign tlb_unc = tlbh_q[TLBH_UNC_BIT];
   assign tlb_ppn = tlbh_q[TLBH_PPN_LSB +: VPN_W];

   assign tlb_miss = ~(tlb_v & (tlb_tag == vpn_q));
   // RX governs root mode, UX user mode
   assign perm_denied = (rm_q & ~tlb_rx) | (~rm_q & ~tlb_ux);

   // Page fault only on a hit, so never together with a miss
   assign itm = tlb_miss & imme_q;
   assign ipf = perm_denied & ~tlb_miss & imme_q;

   // Identity mapping with translation off
   assign ppn = imme_q ? tlb_ppn : vpn_q;

   // Lower half of physical space is uncached
   assign seg_unc = (ENABLE_UNCACHED_SEG != 0) ? (~itm & ~ipf & ~ppn[VPN_W-1]) : 1'b0;
   assign uncached = (imme_q & ~tlb_miss & ~perm_denied & tlb_unc) | seg_unc;

endmodule

`default_nettype wire

// ==== src/immu_cfg_pkg.sv ====
// Instruction MMU configuration
// Address and page geometry, TLB size and result queue depth,
// plus the vector types that carry these widths through the design
`default_nettype none

package immu_cfg_pkg;

   // Address and MSR word widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // 4 KiB pages
   localparam int PAGE_SHIFT = 12;
   // Page number width, same for VPN and PPN
   localparam int VPN_W = ADDR_W - PAGE_SHIFT;

   // Direct-mapped TLB, 4 sets, index must fit inside the VPN
   localparam int TLB_IDX_W = 2;
   localparam int TLB_ENTRIES = 1 << TLB_IDX_W;

   // Result queue slots, also the requester's initial credits
   localparam int QUEUE_DEPTH = 4;
   localparam int QUEUE_PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

   // Page number, virtual or physical
   typedef logic [VPN_W-1:0] vpn_t;
   typedef logic [TLB_IDX_W-1:0] tlb_idx_t;
   typedef logic [DATA_W-1:0] msr_data_t;
   typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;
   typedef logic [QUEUE_CNT_W-1:0] queue_cnt_t;

endpackage

`default_nettype wire

// ==== src/immu_msr_pkg.sv ====
// Instruction MMU machine-specific registers
// MSR address map and bit positions of the PSR and TLB entry words
`default_nettype none

package immu_msr_pkg;
   import immu_cfg_pkg::*;

   localparam int MSR_ADDR_W = 10;
   typedef logic [MSR_ADDR_W-1:0] msr_addr_t;

   // Register addresses
   localparam msr_addr_t MSR_PSR = 10'h000;
   localparam msr_addr_t MSR_IMMID = 10'h001;
   // Entry index sits in the low TLB_IDX_W address bits
   localparam msr_addr_t MSR_TLBL_BASE = 10'h100;
   localparam msr_addr_t MSR_TLBH_BASE = 10'h180;

   // PSR bits
   localparam int PSR_RM_BIT = 0;
   localparam int PSR_IMME_BIT = 1;

   // TLBL: valid bit, VPN tag in the top bits
   localparam int TLBL_V_BIT = 0;
   localparam int TLBL_TAG_LSB = DATA_W - VPN_W;

   // TLBH: attribute bits, PPN in the top bits
   localparam int TLBH_P_BIT = 0;
   localparam int TLBH_UX_BIT = 3;
   localparam int TLBH_RX_BIT = 4;
   localparam int TLBH_UNC_BIT = 7;
   localparam int TLBH_S_BIT = 8;
   localparam int TLBH_PPN_LSB = DATA_W - VPN_W;

endpackage

`default_nettype wire

// ==== src/immu_top.sv ====
// Instruction MMU top level
// MSR decoder, TLB lookup and credit-returning result queue;
// requests in, translated fetch results out
`timescale 1ns/1ps
`default_nettype none

module immu_top (
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      req_valid,
   input  immu_cfg_pkg::vpn_t       req_vpn,
   output logic                     req_credit,
   output logic                     res_valid,
   output immu_cfg_pkg::vpn_t       res_ppn,
   output logic                     res_itm,
   output logic                     res_ipf,
   output logic                     res_uncached,
   input  wire                      res_ack,
   input  wire                      msr_we,
   input  immu_msr_pkg::msr_addr_t  msr_addr,
   input  immu_cfg_pkg::msr_data_t  msr_wdata,
   output immu_cfg_pkg::msr_data_t  msr_rdata
);
   import immu_cfg_pkg::*;

   // Decoder to lookup
   logic psr_imme;
   logic psr_rm;
   logic tlbl_we;
   logic tlbh_we;
   tlb_idx_t tlb_widx;

   // Lookup to queue
   logic lookup_valid;
   vpn_t lookup_ppn;
   logic lookup_itm;
   logic lookup_ipf;
   logic lookup_uncached;

   msr_decode u_decode (
      .clk       (clk),
      .reset     (reset),
      .msr_we    (msr_we),
      .msr_addr  (msr_addr),
      .msr_wdata (msr_wdata),
      .msr_rdata (msr_rdata),
      .psr_imme  (psr_imme),
      .psr_rm    (psr_rm),
      .tlbl_we   (tlbl_we),
      .tlbh_we   (tlbh_we),
      .tlb_widx  (tlb_widx)
   );

   // Lower-half uncached segment on
   immu #(
      .ENABLE_UNCACHED_SEG (1)
   ) u_immu (
      .clk       (clk),
      .reset     (reset),
      .re        (req_valid),
      .vpn       (req_vpn),
      .psr_imme  (psr_imme),
      .psr_rm    (psr_rm),
      .tlbl_we   (tlbl_we),
      .tlbh_we   (tlbh_we),
      .tlb_widx  (tlb_widx),
      .tlb_wdata (msr_wdata),
      .valid     (lookup_valid),
      .ppn       (lookup_ppn),
      .itm       (lookup_itm),
      .ipf       (lookup_ipf),
      .uncached  (lookup_uncached)
   );

   fetch_result_queue u_result (
      .clk           (clk),
      .reset         (reset),
      .push          (lookup_valid),
      .push_ppn      (lookup_ppn),
      .push_itm      (lookup_itm),
      .push_ipf      (lookup_ipf),
      .push_uncached (lookup_uncached),
      .pop           (res_ack),
      .res_valid     (res_valid),
      .res_ppn       (res_ppn),
      .res_itm       (res_itm),
      .res_ipf       (res_ipf),
      .res_uncached  (res_uncached),
      .credit        (req_credit)
   );

endmodule

`default_nettype wire

// ==== src/msr_decode.sv ====
// MSR access decoder
// Holds the PSR bits, turns MSR writes into TLB word write strobes
// with the entry index, and returns read data for PSR and IMMID
`timescale 1ns/1ps
`default_nettype none

module msr_decode (
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      msr_we,
   input  immu_msr_pkg::msr_addr_t  msr_addr,
   input  immu_cfg_pkg::msr_data_t  msr_wdata,
   output immu_cfg_pkg::msr_data_t  msr_rdata,
   output logic                     psr_imme,
   output logic                     psr_rm,
   output logic                     tlbl_we,
   output logic                     tlbh_we,
   output immu_cfg_pkg::tlb_idx_t   tlb_widx
);
   import immu_cfg_pkg::*;
   import immu_msr_pkg::*;

   // IMMID reports the TLB index width in its low 3 bits
   localparam msr_data_t IMMID_VALUE = msr_data_t'(TLB_IDX_W % 8);

   logic is_psr;
   logic is_immid;
   logic is_tlbl;
   logic is_tlbh;

   // Address match
   assign is_psr = (msr_addr == MSR_PSR);
   assign is_immid = (msr_addr == MSR_IMMID);
   // TLB windows ignore the index bits
   assign is_tlbl = (msr_addr[MSR_ADDR_W-1:TLB_IDX_W] ==
                     MSR_TLBL_BASE[MSR_ADDR_W-1:TLB_IDX_W]);
   assign is_tlbh = (msr_addr[MSR_ADDR_W-1:TLB_IDX_W] ==
                     MSR_TLBH_BASE[MSR_ADDR_W-1:TLB_IDX_W]);

   // TLB write strobes and entry index
   assign tlbl_we = msr_we & is_tlbl;
   assign tlbh_we = msr_we & is_tlbh;
   assign tlb_widx = msr_addr[TLB_IDX_W-1:0];

   // PSR, translation off out of reset
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         psr_imme <= 1'b0;
         psr_rm <= 1'b0;
      end
      else if (msr_we && is_psr)
      begin
         psr_imme <= msr_wdata[PSR_IMME_BIT];
         psr_rm <= msr_wdata[PSR_RM_BIT];
      end
   end

   // Read mux, TLB words are write-only
   always_comb
   begin
      msr_rdata = '0;
      if (is_psr)
      begin
         msr_rdata[PSR_IMME_BIT] = psr_imme;
         msr_rdata[PSR_RM_BIT] = psr_rm;
      end
      else if (is_immid)
      begin
         msr_rdata = IMMID_VALUE;
      end
   end

endmodule

`default_nettype wire

// ==== src/tlb_entry_ram.sv ====
// TLB word array
// One synchronous write port and one registered read port;
// a same-index read and write at one edge returns the old word
`timescale 1ns/1ps
`default_nettype none

module tlb_entry_ram (
   input  wire                      clk,
   input  wire                      re,
   input  immu_cfg_pkg::tlb_idx_t   raddr,
   output immu_cfg_pkg::msr_data_t  rdata,
   input  wire                      we,
   input  immu_cfg_pkg::tlb_idx_t   waddr,
   input  immu_cfg_pkg::msr_data_t  wdata
);
   import immu_cfg_pkg::*;

   // One word per TLB set
   msr_data_t mem [TLB_ENTRIES];

   // Write port
   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[waddr] <= wdata;
      end
   end

   // Read port, holds last word while re is low
   always_ff @(posedge clk)
   begin
      if (re)
      begin
         rdata <= mem[raddr];
      end
   end

endmodule

`default_nettype wire

// ==== verification/immu_tb.sv ====
// Instruction MMU testbench
// Sends fetch requests and MSR accesses to immu_top, predicts every
// translation from a shadow TLB and PSR, and checks results in order,
// credit return under back-pressure and MSR read data
`timescale 1ns/1ps
`default_nettype none

module immu_tb;
   import immu_cfg_pkg::*;
   import immu_msr_pkg::*;

   localparam int RESET_CYCLES = 16;
   localparam int OFF_REQS = 16;
   // Per mode: hit, tag miss, random per entry, plus one invalid entry
   localparam int ON_REQS = 2 * (TLB_ENTRIES * 3 + 1);
   localparam int TAIL_REQS = 16;
   localparam int NUM_REQ = OFF_REQS + ON_REQS + QUEUE_DEPTH + TAIL_REQS;
   // Expected result packed as {ppn, itm, ipf, uncached}
   localparam int RES_W = VPN_W + 3;

   logic clk = 1'b0;
   logic reset = 1'b1;
   logic req_valid = 1'b0;
   vpn_t req_vpn = '0;
   logic req_credit;
   logic res_valid;
   vpn_t res_ppn;
   logic res_itm;
   logic res_ipf;
   logic res_uncached;
   logic res_ack = 1'b0;
   logic msr_we = 1'b0;
   msr_addr_t msr_addr = '0;
   msr_data_t msr_wdata = '0;
   msr_data_t msr_rdata;

   integer seed = 52;
   int value_errors = 0;
   int proto_errors = 0;
   int credits = QUEUE_DEPTH;
   int credit_pulses = 0;
   int pops = 0;
   logic pop_prev = 1'b0;
   // 0 random, 1 held low, 2 always high
   int ack_mode = 2;

   // Shadow state, updated after each MSR write edge
   msr_data_t tlbl_sh [TLB_ENTRIES];
   msr_data_t tlbh_sh [TLB_ENTRIES];
   logic sh_imme = 1'b0;
   logic sh_rm = 1'b0;
   logic [RES_W-1:0] expected [$];

   immu_top DUT (
      .clk          (clk),
      .reset        (reset),
      .req_valid    (req_valid),
      .req_vpn      (req_vpn),
      .req_credit   (req_credit),
      .res_valid    (res_valid),
      .res_ppn      (res_ppn),
      .res_itm      (res_itm),
      .res_ipf      (res_ipf),
      .res_uncached (res_uncached),
      .res_ack      (res_ack),
      .msr_we       (msr_we),
      .msr_addr     (msr_addr),
      .msr_wdata    (msr_wdata),
      .msr_rdata    (msr_rdata)
   );

   always #5 clk = ~clk;

   // Expected translation for one request
   function automatic logic [RES_W-1:0] ref_translate(input vpn_t vpn, input logic imme,
                                                      input logic rm, input msr_data_t lo,
                                                      input msr_data_t hi);
      logic hit;
      logic denied;
      logic itm;
      logic ipf;
      logic unc;
      vpn_t ppn;
      hit = lo[TLBL_V_BIT] && (lo[TLBL_TAG_LSB +: VPN_W] == vpn);
      // Root mode needs RX, user mode UX
      denied = rm ? !hi[TLBH_RX_BIT] : !hi[TLBH_UX_BIT];
      itm = imme && !hit;
      ipf = imme && hit && denied;
      ppn = imme ? hi[TLBH_PPN_LSB +: VPN_W] : vpn;
      // UNC attribute, or lower half of physical space
      unc = (imme && hit && !denied && hi[TLBH_UNC_BIT]) || (!itm && !ipf && !ppn[VPN_W-1]);
      return {ppn, itm, ipf, unc};
   endfunction

   function automatic msr_data_t psr_word(input logic imme, input logic rm);
      msr_data_t w;
      w = '0;
      w[PSR_IMME_BIT] = imme;
      w[PSR_RM_BIT] = rm;
      return w;
   endfunction

   // Consumer ack, coin drawn at the edge and driven 1 ns later
   always @(posedge clk)
   begin
      logic coin;
      coin = 1'($random(seed));
      #1;
      res_ack = (ack_mode == 2) || ((ack_mode == 0) && coin);
   end

   // Result compare and credit tracking
   always @(posedge clk)
   begin
      logic [RES_W-1:0] exp;
      if (!reset)
      begin
         // One credit pulse exactly one cycle after each pop
         if (req_credit !== pop_prev)
         begin
            $display("Credit pulse does not match a pop one cycle earlier at %0t", $time);
            proto_errors++;
         end
         if (req_credit)
         begin
            credits++;
            credit_pulses++;
         end
         if (credits > QUEUE_DEPTH)
         begin
            $display("More credits returned than requests sent at %0t", $time);
            proto_errors++;
         end
         pop_prev = res_valid && res_ack;
         if (res_valid && res_ack)
         begin
            pops++;
            if (expected.size() == 0)
            begin
               $display("Result arrived with nothing expected at %0t", $time);
               proto_errors++;
            end
            else
            begin
               exp = expected.pop_front();
               if (res_ppn !== exp[RES_W-1:3])
               begin
                  $display("** Error res_ppn: expected %0h, got %0h", exp[RES_W-1:3], res_ppn);
                  value_errors++;
               end
               if (res_itm !== exp[2])
               begin
                  $display("** Error res_itm: expected %0h, got %0h", exp[2], res_itm);
                  value_errors++;
               end
               if (res_ipf !== exp[1])
               begin
                  $display("** Error res_ipf: expected %0h, got %0h", exp[1], res_ipf);
                  value_errors++;
               end
               if (res_uncached !== exp[0])
               begin
                  $display("** Error res_uncached: expected %0h, got %0h", exp[0], res_uncached);
                  value_errors++;
               end
            end
         end
      end
   end

   // All stimulus tasks start and end 1 ns after a rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic msr_write(input msr_addr_t addr, input msr_data_t data);
      msr_we = 1'b1;
      msr_addr = addr;
      msr_wdata = data;
      next_cycle();
      msr_we = 1'b0;
   endtask

   task automatic write_psr(input logic imme, input logic rm);
      msr_write(MSR_PSR, psr_word(imme, rm));
      sh_imme = imme;
      sh_rm = rm;
   endtask

   task automatic write_tlbl(input tlb_idx_t idx, input msr_data_t lo);
      msr_write(MSR_TLBL_BASE | msr_addr_t'(idx), lo);
      tlbl_sh[idx] = lo;
   endtask

   task automatic write_tlbh(input tlb_idx_t idx, input msr_data_t hi);
      msr_write(MSR_TLBH_BASE | msr_addr_t'(idx), hi);
      tlbh_sh[idx] = hi;
   endtask

   // Combinational read, sampled mid-cycle
   task automatic read_check(input msr_addr_t addr, input msr_data_t exp);
      msr_addr = addr;
      @(negedge clk);
      if (msr_rdata !== exp)
      begin
         $display("** Error msr_rdata @%0h: expected %0h, got %0h", addr, exp, msr_rdata);
         value_errors++;
      end
      next_cycle();
   endtask

   task automatic send_request(input vpn_t v);
      int waited;
      tlb_idx_t idx;
      waited = 0;
      idx = v[TLB_IDX_W-1:0];
      while (credits == 0 && waited < 8 * QUEUE_DEPTH)
      begin
         next_cycle();
         waited++;
      end
      if (credits == 0)
      begin
         $display("Request for vpn %0h not sent, no credit came back", v);
         proto_errors++;
      end
      else
      begin
         req_valid = 1'b1;
         req_vpn = v;
         credits--;
         expected.push_back(ref_translate(v, sh_imme, sh_rm, tlbl_sh[idx], tlbh_sh[idx]));
         next_cycle();
         req_valid = 1'b0;
      end
   endtask

   // Valid entry with a random tag for this set and a random PPN
   task automatic program_entry(input tlb_idx_t idx, input logic ux, input logic rx);
      vpn_t tag;
      msr_data_t lo;
      msr_data_t hi;
      tag = vpn_t'($random(seed));
      tag[TLB_IDX_W-1:0] = idx;
      lo = '0;
      lo[TLBL_TAG_LSB +: VPN_W] = tag;
      lo[TLBL_V_BIT] = 1'b1;
      hi = '0;
      hi[TLBH_PPN_LSB +: VPN_W] = vpn_t'($random(seed));
      hi[TLBH_UX_BIT] = ux;
      hi[TLBH_RX_BIT] = rx;
      hi[TLBH_UNC_BIT] = 1'($random(seed));
      hi[TLBH_P_BIT] = 1'b1;
      hi[TLBH_S_BIT] = 1'($random(seed));
      write_tlbl(idx, lo);
      write_tlbh(idx, hi);
   endtask

   task automatic translated_pass(input logic rm);
      vpn_t tag;
      msr_data_t lo;
      // Entry 0 always faults, entry 1 always allowed
      program_entry(0, 1'b0, 1'b0);
      program_entry(1, 1'b1, 1'b1);
      for (int i = 2; i < TLB_ENTRIES; i++)
      begin
         program_entry(tlb_idx_t'(i), 1'($random(seed)), 1'($random(seed)));
      end
      write_psr(1'b1, rm);
      read_check(MSR_PSR, psr_word(1'b1, rm));
      // TLB words hold nonzero data here, reads still return zero
      read_check(MSR_TLBL_BASE | msr_addr_t'(1), '0);
      read_check(MSR_TLBH_BASE | msr_addr_t'(1), '0);
      for (int i = 0; i < TLB_ENTRIES; i++)
      begin
         tag = tlbl_sh[i][TLBL_TAG_LSB +: VPN_W];
         send_request(tag);
         // Same set, different tag
         send_request(tag ^ (vpn_t'(1) << TLB_IDX_W));
         send_request(vpn_t'($random(seed)));
      end
      // Invalidate the last entry and hit its old tag
      lo = tlbl_sh[TLB_ENTRIES-1];
      lo[TLBL_V_BIT] = 1'b0;
      write_tlbl(tlb_idx_t'(TLB_ENTRIES - 1), lo);
      send_request(lo[TLBL_TAG_LSB +: VPN_W]);
   endtask

   task automatic drain();
      while (expected.size() != 0 || credits != QUEUE_DEPTH)
      begin
         next_cycle();
      end
   endtask

   // Watchdog, 20 cycles per request on top of reset
   initial
   begin
      #((RESET_CYCLES + 20 * NUM_REQ) * 10);
      $display("Timeout, %0d results still outstanding", expected.size());
      $display("value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial
   begin
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;

      // All entries invalid before any enable
      for (int i = 0; i < TLB_ENTRIES; i++)
      begin
         write_tlbl(tlb_idx_t'(i), '0);
         write_tlbh(tlb_idx_t'(i), '0);
      end

      // MSR reads
      read_check(MSR_PSR, '0);
      read_check(MSR_IMMID, msr_data_t'(TLB_IDX_W));
      write_psr(1'b0, 1'b1);
      read_check(MSR_PSR, psr_word(1'b0, 1'b1));

      // Translation off, identity mapping
      ack_mode = 0;
      write_psr(1'b0, 1'b0);
      for (int i = 0; i < OFF_REQS; i++)
      begin
         send_request(vpn_t'($random(seed)));
      end

      // User mode then root mode
      translated_pass(1'b0);
      translated_pass(1'b1);

      // Back-pressure, a full queue returns nothing
      drain();
      ack_mode = 1;
      for (int i = 0; i < QUEUE_DEPTH; i++)
      begin
         send_request(vpn_t'($random(seed)));
      end
      repeat (8) next_cycle();
      if (credits != 0)
      begin
         $display("Credit returned while res_ack was held low");
         proto_errors++;
      end

      // Random traffic with acks back on
      ack_mode = 0;
      write_psr(1'b1, 1'($random(seed)));
      for (int i = 0; i < TAIL_REQS; i++)
      begin
         send_request(vpn_t'($random(seed)));
      end
      ack_mode = 2;
      drain();
      if (credit_pulses != pops)
      begin
         $display("Saw %0d credit pulses for %0d pops", credit_pulses, pops);
         proto_errors++;
      end

      $display("value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
      if (value_errors == 0 && proto_errors == 0)
      begin
         $display("*** TEST PASSED ***");
      end
      else
      begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
